/* dv/tb_assert.sv */
`default_nettype none

module tb_assert (
    input wire                              aclk_i,
    input wire                              arst_n_i,
    input wire                              arvalid_i,
    input wire                              arready_i,
    input wire [mem_map_pkg::ADDR_W-1:0]    araddr_i,
    input wire [axi_rd_pkg::AXI_ID_W-1:0]   arid_i,
    input wire [axi_rd_pkg::AXI_LEN_W-1:0]  arlen_i,
    input wire                              rvalid_i,
    input wire                              rready_i,
    input wire                              inst_ok_i,
    input wire                              data_ok_i
);

    // a pending request keeps its fields until accepted
    a_ar_hold: assert property (@(posedge aclk_i) disable iff (!arst_n_i)
        arvalid_i && !arready_i |=> arvalid_i && $stable(araddr_i) && $stable(arid_i)
        && $stable(arlen_i))
    else $error("read address request changed under back-pressure");

    // every beat belongs to a request that is still waiting
    a_r_accept: assert property (@(posedge aclk_i) disable iff (!arst_n_i)
        rvalid_i |-> rready_i)
    else $error("read beat offered while rready_o was low");

    a_rst_quiet: assert property (@(posedge aclk_i)
        $rose(arst_n_i) |-> !arvalid_i && !rready_i && !inst_ok_i && !data_ok_i)
    else $error("read master active in the first cycle after reset");

endmodule

bind mem_read_top tb_assert u_assert (
    .aclk_i    (aclk),
    .arst_n_i  (arst_n_i),
    .arvalid_i (arvalid_o),
    .arready_i (arready_i),
    .araddr_i  (araddr_o),
    .arid_i    (arid_o),
    .arlen_i   (arlen_o),
    .rvalid_i  (rvalid_i),
    .rready_i  (rready_o),
    .inst_ok_i (inst_data_ok_o),
    .data_ok_i (data_data_ok_o)
);

`default_nettype wire

/* dv/tb_axi_mem.sv */
`default_nettype none

module tb_axi_mem #(
    parameter logic [31:0] PAT_KEY = 32'h0
) (
    input  wire                               aclk_i,
    input  wire                               arst_n_i,
    input  wire  [axi_rd_pkg::AXI_ID_W-1:0]   arid_i,
    input  wire  [mem_map_pkg::ADDR_W-1:0]    araddr_i,
    input  wire  [axi_rd_pkg::AXI_LEN_W-1:0]  arlen_i,
    input  wire                               arvalid_i,
    output logic                              arready_o,
    output logic [axi_rd_pkg::AXI_ID_W-1:0]   rid_o,
    output logic [axi_rd_pkg::AXI_DATA_W-1:0] rdata_o,
    output logic                              rlast_o,
    output logic                              rvalid_o,
    input  wire                               rready_i
);
    import axi_rd_pkg::*;
    import mem_map_pkg::*;

    integer                seed;
    logic [AXI_ID_W-1:0]   q_id[$];          // accepted requests, served in order
    logic [ADDR_W-1:0]     q_addr[$];
    logic [AXI_LEN_W-1:0]  q_len[$];
    logic                  busy;
    logic [ADDR_W-1:0]     cur_addr;
    logic [AXI_LEN_W-1:0]  beats_left;
    logic                  beat_free;

    function automatic logic [AXI_DATA_W-1:0] mem_word(input logic [ADDR_W-1:0] addr);
        return {2'b00, addr[ADDR_W-1:2]} ^ PAT_KEY;
    endfunction

    initial seed = 50;

    always @(posedge aclk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            arready_o <= 1'b0;
            rvalid_o  <= 1'b0;
            rlast_o   <= 1'b0;
            rid_o     <= '0;
            rdata_o   <= '0;
            busy       = 1'b0;
            cur_addr   = '0;
            beats_left = '0;
            q_id.delete();
            q_addr.delete();
            q_len.delete();
        end else begin
            arready_o <= (($random(seed) & 3) != 0);   // stall about one cycle in four
            if (arvalid_i && arready_o) begin
                q_id.push_back(arid_i);
                q_addr.push_back(araddr_i);
                q_len.push_back(arlen_i);
            end
            beat_free = !rvalid_o || rready_i;
            if (rvalid_o && rready_i) begin
                rvalid_o <= 1'b0;
                if (rlast_o) begin
                    busy = 1'b0;
                end else begin
                    cur_addr   = cur_addr + 32'd4;
                    beats_left = beats_left - 1'b1;
                end
            end
            if (!busy && (q_id.size() > 0)) begin
                rid_o     <= q_id.pop_front();
                cur_addr   = q_addr.pop_front();
                beats_left = q_len.pop_front();
                busy       = 1'b1;
            end
            if (busy && beat_free && (($random(seed) & 3) != 0)) begin
                rvalid_o <= 1'b1;
                rdata_o  <= mem_word(cur_addr);
                rlast_o  <= (beats_left == '0);
            end
        end
    end

endmodule

`default_nettype wire

/* dv/tb_clk_gen.sv */
`default_nettype none

module tb_clk_gen #(
    parameter int PERIOD     = 8,
    parameter int RST_CYCLES = 16
) (
    output logic aclk_o,
    output logic arst_n_o
);

    initial begin
        aclk_o = 1'b0;
        forever #(PERIOD / 2) aclk_o = ~aclk_o;
    end

    initial begin
        arst_n_o = 1'b0;
        repeat (RST_CYCLES) @(posedge aclk_o);
        arst_n_o <= 1'b1;                    // release on a clock edge
    end

endmodule

`default_nettype wire

/* dv/tb_top.sv */
`default_nettype none

module tb_top;
    import axi_rd_pkg::*;
    import mem_map_pkg::*;

    localparam int          PERIOD  = 8;
    localparam int          RST_CYC = 16;
    localparam int          INST_ID = 2;
    localparam int          DATA_ID = 5;
    localparam logic [31:0] PAT_KEY = 32'h5a3c_9e17;
    localparam int          N_SEQ   = 12;
    localparam int          N_LOAD  = 10;
    localparam int          N_BOTH  = 6;
    localparam int          N_REQ   = N_SEQ + N_LOAD + 2 * N_BOTH;
    localparam int          MAX_LAT = 200;     // cycles per request, stalls included

    logic                  aclk;
    logic                  arst_n;
    logic                  inst_req_i;
    logic [ADDR_W-1:0]     inst_addr_i;
    logic                  inst_addr_ready_o;
    logic [AXI_DATA_W-1:0] inst_rdata_o;
    logic [ADDR_W-1:0]     inst_addr_out_o;
    logic                  inst_data_ok_o;
    logic                  data_req_i;
    logic [ADDR_W-1:0]     data_addr_i;
    logic                  data_addr_ok_o;
    logic                  data_data_ok_o;
    logic [AXI_DATA_W-1:0] data_rdata_o;
    logic [AXI_ID_W-1:0]   arid_o;
    logic [ADDR_W-1:0]     araddr_o;
    logic [AXI_LEN_W-1:0]  arlen_o;
    logic                  arvalid_o;
    logic                  arready_i;
    logic [AXI_ID_W-1:0]   rid_i;
    logic [AXI_DATA_W-1:0] rdata_i;
    logic                  rlast_i;
    logic                  rvalid_i;
    logic                  rready_o;

    integer                seed;
    int                    errors;
    int                    n_fetch;
    int                    n_load;
    int                    inst_ok_cnt;
    int                    data_ok_cnt;
    int                    addr_ok_cnt;
    int                    post_rst;
    logic [ADDR_W-1:0]     acc_inst_addr;     // address taken by the fetcher
    logic [ADDR_W-1:0]     acc_data_addr;
    logic                  inst_busy;         // fetch taken and not yet returned
    logic                  expect_data_first;
    logic                  last_inst_q;
    logic                  last_data_q;
    logic                  stall_q;
    logic [ADDR_W-1:0]     stall_addr_q;
    logic [AXI_ID_W-1:0]   stall_id_q;
    logic [AXI_LEN_W-1:0]  stall_len_q;

    tb_clk_gen #(.PERIOD(PERIOD), .RST_CYCLES(RST_CYC)) u_clk (
        .aclk_o   (aclk),
        .arst_n_o (arst_n)
    );

    mem_read_top #(.INST_ID(INST_ID), .DATA_ID(DATA_ID)) DUT (
        .aclk (aclk), .arst_n_i (arst_n),
        .inst_req_i (inst_req_i), .inst_addr_i (inst_addr_i),
        .inst_addr_ready_o (inst_addr_ready_o), .inst_rdata_o (inst_rdata_o),
        .inst_addr_out_o (inst_addr_out_o), .inst_data_ok_o (inst_data_ok_o),
        .data_req_i (data_req_i), .data_addr_i (data_addr_i),
        .data_addr_ok_o (data_addr_ok_o), .data_data_ok_o (data_data_ok_o),
        .data_rdata_o (data_rdata_o),
        .arid_o (arid_o), .araddr_o (araddr_o), .arlen_o (arlen_o),
        .arvalid_o (arvalid_o), .arready_i (arready_i), .rid_i (rid_i),
        .rdata_i (rdata_i), .rlast_i (rlast_i), .rvalid_i (rvalid_i),
        .rready_o (rready_o)
    );

    tb_axi_mem #(.PAT_KEY(PAT_KEY)) u_mem (
        .aclk_i (aclk), .arst_n_i (arst_n),
        .arid_i (arid_o), .araddr_i (araddr_o), .arlen_i (arlen_o),
        .arvalid_i (arvalid_o), .arready_o (arready_i), .rid_o (rid_i),
        .rdata_o (rdata_i), .rlast_o (rlast_i), .rvalid_o (rvalid_i),
        .rready_i (rready_o)
    );

    // word at a byte address is its word index xor the key
    function automatic logic [31:0] expected_word(input logic [31:0] addr);
        return (addr >> 2) ^ PAT_KEY;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] exp_v,
                                   input logic [31:0] got_v);
        errors++;
        $display("mismatch at %0t: %s expected %h got %h", $time, name, exp_v, got_v);
    endtask

    task automatic report_error(input string what);
        errors++;
        $display("error at %0t: %s", $time, what);
    endtask

    // all checks sample at the falling edge, away from the driving edge
    always @(negedge aclk) begin
        if (!arst_n || post_rst == 0) begin
            assert (!arvalid_o && !rready_o && !inst_data_ok_o && !data_addr_ok_o
                    && !data_data_ok_o)
            else report_error("outputs active during or right after reset");
        end
        if (arst_n) begin
            post_rst++;
            if (inst_data_ok_o) begin
                inst_busy = 1'b0;             // fetcher is idle again with its result
            end
            assert (inst_addr_ready_o == !inst_busy)
            else report_mismatch("inst_addr_ready_o", 32'(!inst_busy),
                                 32'(inst_addr_ready_o));
            if (inst_req_i && !inst_busy) begin
                acc_inst_addr = inst_addr_i;
                inst_busy     = 1'b1;
            end
            if (data_req_i) acc_data_addr = data_addr_i;
            if (data_addr_ok_o) addr_ok_cnt++;

            assert (inst_data_ok_o == last_inst_q)
            else report_error("inst_data_ok_o does not follow the last instruction beat");
            assert (data_data_ok_o == last_data_q)
            else report_error("data_data_ok_o does not follow the data beat");

            if (inst_data_ok_o) begin
                inst_ok_cnt++;
                assert (inst_addr_out_o == acc_inst_addr)
                else report_mismatch("inst_addr_out_o", acc_inst_addr, inst_addr_out_o);
                assert (inst_rdata_o == expected_word(acc_inst_addr))
                else report_mismatch("inst_rdata_o", expected_word(acc_inst_addr),
                                     inst_rdata_o);
            end
            if (data_data_ok_o) begin
                data_ok_cnt++;
                assert (data_rdata_o == expected_word(acc_data_addr))
                else report_mismatch("data_rdata_o", expected_word(acc_data_addr),
                                     data_rdata_o);
            end

            if (arvalid_o && arready_i) begin
                if (expect_data_first) begin
                    assert (arid_o == AXI_ID_W'(DATA_ID))
                    else report_mismatch("arid_o", DATA_ID, 32'(arid_o));
                    expect_data_first = 1'b0;
                end
                if (arid_o == AXI_ID_W'(INST_ID)) begin
                    assert (araddr_o == {acc_inst_addr[31:5], 5'b0})
                    else report_mismatch("araddr_o", {acc_inst_addr[31:5], 5'b0}, araddr_o);
                    assert (arlen_o == 4'd7)
                    else report_mismatch("arlen_o", 32'd7, 32'(arlen_o));
                end else if (arid_o == AXI_ID_W'(DATA_ID)) begin
                    assert (araddr_o == {acc_data_addr[31:2], 2'b0})
                    else report_mismatch("araddr_o", {acc_data_addr[31:2], 2'b0}, araddr_o);
                    assert (arlen_o == 4'd0)
                    else report_mismatch("arlen_o", 32'd0, 32'(arlen_o));
                end else begin
                    report_error("read address carries an unknown arid");
                end
            end

            if (stall_q) begin
                assert (arvalid_o && araddr_o == stall_addr_q && arid_o == stall_id_q
                        && arlen_o == stall_len_q)
                else report_error("read address request changed while arready_i was low");
            end
            stall_q      = arvalid_o && !arready_i;
            stall_addr_q = araddr_o;
            stall_id_q   = arid_o;
            stall_len_q  = arlen_o;

            last_inst_q = rvalid_i && rready_o && rlast_i && (rid_i == AXI_ID_W'(INST_ID));
            last_data_q = rvalid_i && rready_o && (rid_i == AXI_ID_W'(DATA_ID));
        end
    end

    task automatic run_req(input logic do_inst, input logic [31:0] i_addr,
                           input logic do_data, input logic [31:0] d_addr);
        int c_i;
        int c_d;
        c_i = inst_ok_cnt;
        c_d = data_ok_cnt;
        @(posedge aclk);
        if (do_inst) begin
            inst_req_i  <= 1'b1;
            inst_addr_i <= i_addr;
            n_fetch++;
        end
        if (do_data) begin
            data_req_i  <= 1'b1;
            data_addr_i <= d_addr;
            n_load++;
        end
        expect_data_first = do_inst && do_data;
        @(posedge aclk);
        inst_req_i <= 1'b0;
        data_req_i <= 1'b0;
        while ((do_inst && inst_ok_cnt == c_i) || (do_data && data_ok_cnt == c_d)) begin
            @(posedge aclk);
        end
    endtask

    initial begin
        inst_req_i  = 1'b0;
        inst_addr_i = '0;
        data_req_i  = 1'b0;
        data_addr_i = '0;
        seed = 50;
        errors = 0;
        n_fetch = 0;
        n_load = 0;
        inst_ok_cnt = 0;
        data_ok_cnt = 0;
        addr_ok_cnt = 0;
        post_rst = 0;
        inst_busy = 1'b0;
        expect_data_first = 1'b0;
        last_inst_q = 1'b0;
        last_data_q = 1'b0;
        stall_q = 1'b0;
        @(posedge arst_n);
        repeat (2) @(posedge aclk);
        for (int i = 0; i < N_SEQ; i++) begin
            run_req(1'b1, 32'h1000_0fe8 + 32'(4 * i), 1'b0, '0);  // crosses line edges
        end
        for (int i = 0; i < N_LOAD; i++) begin
            run_req(1'b0, '0, 1'b1, $random(seed));
        end
        for (int i = 0; i < N_BOTH; i++) begin
            run_req(1'b1, $random(seed), 1'b1, $random(seed));
        end
        repeat (4) @(posedge aclk);
        if (inst_ok_cnt != n_fetch || data_ok_cnt != n_load || addr_ok_cnt != n_load) begin
            report_error("number of completed requests differs from the number issued");
        end
        $display("checks done: %0d errors, %0d fetches, %0d loads", errors, n_fetch, n_load);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        #((RST_CYC + N_REQ * MAX_LAT) * PERIOD);
        $display("error: timeout, requests did not complete in time");
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# build and run the read-path testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_top -f tb.f -o sim_tb
status=$?
if [ $status -ne 0 ]; then
    echo "compile failed with status $status"
    exit 1
fi

out=$(./obj_dir/sim_tb 2>&1)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -q "Simulation completed successfully"; then
    exit 0
fi
echo "pass message not found"
exit 1

/* tb.f */
verilog/axi_rd_pkg.sv
verilog/mem_map_pkg.sv
verilog/inst_line_fetch.sv
verilog/data_read_port.sv
verilog/axi_read_arbiter.sv
verilog/mem_read_top.sv
dv/tb_clk_gen.sv
dv/tb_axi_mem.sv
dv/tb_assert.sv
dv/tb_top.sv

/* verilog/axi_rd_pkg.sv */
`default_nettype none

package axi_rd_pkg;

    localparam int AXI_ID_W   = 4;
    localparam int AXI_DATA_W = 32;
    localparam int AXI_LEN_W  = 4;                   // AXI3 style length field

    // fixed read-address fields driven on every request
    localparam logic [2:0] AXI_SIZE_WORD  = 3'b010;  // 4 bytes per beat
    localparam logic [1:0] AXI_BURST_INCR = 2'b01;   // line refill walks up the line

endpackage

`default_nettype wire

/* verilog/axi_read_arbiter.sv */
`default_nettype none

module axi_read_arbiter #(
    parameter int unsigned INST_ID = 0,
    parameter int unsigned DATA_ID = 1
) (
    input  wire                               aclk,
    input  wire                               arst_n_i,
    // instruction path
    input  wire                               ir_arvalid_i,
    output logic                              ir_arready_o,
    input  wire  [mem_map_pkg::ADDR_W-1:0]    ir_araddr_i,
    input  wire  [axi_rd_pkg::AXI_LEN_W-1:0]  ir_arlen_i,
    output logic [axi_rd_pkg::AXI_DATA_W-1:0] ir_rdata_o,
    output logic                              ir_rlast_o,
    output logic                              ir_rvalid_o,
    // data path
    input  wire                               mr_arvalid_i,
    output logic                              mr_arready_o,
    input  wire  [mem_map_pkg::ADDR_W-1:0]    mr_araddr_i,
    input  wire  [axi_rd_pkg::AXI_LEN_W-1:0]  mr_arlen_i,
    output logic [axi_rd_pkg::AXI_DATA_W-1:0] mr_rdata_o,
    output logic                              mr_rvalid_o,
    // shared AXI read master
    output logic [axi_rd_pkg::AXI_ID_W-1:0]   arid_o,
    output logic [mem_map_pkg::ADDR_W-1:0]    araddr_o,
    output logic [axi_rd_pkg::AXI_LEN_W-1:0]  arlen_o,
    output logic                              arvalid_o,
    input  wire                               arready_i,
    input  wire  [axi_rd_pkg::AXI_ID_W-1:0]   rid_i,
    input  wire  [axi_rd_pkg::AXI_DATA_W-1:0] rdata_i,
    input  wire                               rlast_i,
    input  wire                               rvalid_i,
    output logic                              rready_o
);
    import axi_rd_pkg::*;

    localparam logic [AXI_ID_W-1:0] INST_ARID = AXI_ID_W'(INST_ID);
    localparam logic [AXI_ID_W-1:0] DATA_ARID = AXI_ID_W'(DATA_ID);

    // read beats are steered by rid alone
    if (INST_ARID == DATA_ARID) begin : g_id_clash
        $error("instruction and data paths need distinct AXI IDs");
    end

    logic lock_q;                             // grant frozen while arvalid waits
    logic lock_data_q;
    logic sel_data;
    logic ar_fire;
    logic inst_pend_q;                        // burst outstanding per ID
    logic data_pend_q;
    logic rid_inst;
    logic rid_data;
    logic r_done;

    // data path has priority on a fresh grant
    assign sel_data = lock_q ? lock_data_q : mr_arvalid_i;

    assign arvalid_o = sel_data ? mr_arvalid_i : ir_arvalid_i;
    assign araddr_o  = sel_data ? mr_araddr_i : ir_araddr_i;
    assign arlen_o   = sel_data ? mr_arlen_i : ir_arlen_i;
    assign arid_o    = sel_data ? DATA_ARID : INST_ARID;
    assign ar_fire   = arvalid_o && arready_i;

    assign mr_arready_o = sel_data && arready_i;
    assign ir_arready_o = !sel_data && arready_i;

    assign rid_inst = (rid_i == INST_ARID) && inst_pend_q;
    assign rid_data = (rid_i == DATA_ARID) && data_pend_q;
    assign rready_o = rid_inst || rid_data;   // accept only for a waiting owner
    assign r_done   = rvalid_i && rlast_i;

    assign ir_rvalid_o = rvalid_i && rid_inst;
    assign ir_rdata_o  = rdata_i;
    assign ir_rlast_o  = rlast_i;
    assign mr_rvalid_o = rvalid_i && rid_data;
    assign mr_rdata_o  = rdata_i;

    always_ff @(posedge aclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            lock_q      <= 1'b0;
            lock_data_q <= 1'b0;
            inst_pend_q <= 1'b0;
            data_pend_q <= 1'b0;
        end else begin
            lock_q      <= arvalid_o && !arready_i;
            lock_data_q <= sel_data;

            if (ar_fire && !sel_data) begin
                inst_pend_q <= 1'b1;
            end else if (r_done && rid_inst) begin
                inst_pend_q <= 1'b0;
            end

            if (ar_fire && sel_data) begin
                data_pend_q <= 1'b1;
            end else if (r_done && rid_data) begin
                data_pend_q <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/data_read_port.sv */
`default_nettype none

module data_read_port #(
    parameter int unsigned DATA_ID = 1
) (
    input  wire                               aclk,
    input  wire                               arst_n_i,
    // core side
    input  wire                               data_req_i,
    input  wire  [mem_map_pkg::ADDR_W-1:0]    data_addr_i,
    output logic                              data_addr_ok_o,
    output logic                              data_data_ok_o,
    output logic [axi_rd_pkg::AXI_DATA_W-1:0] data_rdata_o,
    // toward the read arbiter
    output logic                              mr_arvalid_o,
    input  wire                               mr_arready_i,
    output logic [mem_map_pkg::ADDR_W-1:0]    mr_araddr_o,
    output logic [axi_rd_pkg::AXI_LEN_W-1:0]  mr_arlen_o,
    input  wire  [axi_rd_pkg::AXI_DATA_W-1:0] mr_rdata_i,
    input  wire                               mr_rvalid_i
);
    import axi_rd_pkg::*;
    import mem_map_pkg::*;

    localparam logic [1:0] S_IDLE = 2'd0;
    localparam logic [1:0] S_ADDR = 2'd1;
    localparam logic [1:0] S_WAIT = 2'd2;

    logic [1:0]            state_q;
    logic                  addr_ok_q;
    logic                  data_ok_q;
    logic [ADDR_W-1:0]     addr_q;
    logic [AXI_DATA_W-1:0] rdata_q;
    logic                  take_req;

    if (DATA_ID >= (1 << AXI_ID_W)) begin : g_id_range
        $error("DATA_ID does not fit in the AXI ID field");
    end

    assign take_req = data_req_i && (state_q == S_IDLE);

    always_ff @(posedge aclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q   <= S_IDLE;
            addr_ok_q <= 1'b0;
            data_ok_q <= 1'b0;
        end else begin
            addr_ok_q <= take_req;            // acknowledge the accepted load
            data_ok_q <= 1'b0;
            case (state_q)
                S_IDLE: begin
                    if (take_req) begin
                        state_q <= S_ADDR;
                    end
                end
                S_ADDR: begin
                    if (mr_arready_i) begin
                        state_q <= S_WAIT;
                    end
                end
                S_WAIT: begin
                    if (mr_rvalid_i) begin
                        state_q   <= S_IDLE;
                        data_ok_q <= 1'b1;
                    end
                end
                default: begin
                    state_q <= S_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (take_req) begin
            addr_q <= data_addr_i;
        end
        if ((state_q == S_WAIT) && mr_rvalid_i) begin
            rdata_q <= mr_rdata_i;
        end
    end

    assign data_addr_ok_o = addr_ok_q;
    assign data_data_ok_o = data_ok_q;
    assign data_rdata_o   = rdata_q;

    // one beat at the word holding the load address
    assign mr_arvalid_o = (state_q == S_ADDR);
    assign mr_araddr_o  = {addr_q[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
    assign mr_arlen_o   = '0;

endmodule

`default_nettype wire

/* verilog/inst_line_fetch.sv */
`default_nettype none

module inst_line_fetch #(
    parameter int unsigned INST_ID = 0
) (
    input  wire                               aclk,
    input  wire                               arst_n_i,
    // core side
    input  wire                               inst_req_i,
    input  wire  [mem_map_pkg::ADDR_W-1:0]    inst_addr_i,
    output logic                              inst_addr_ready_o,
    output logic [axi_rd_pkg::AXI_DATA_W-1:0] inst_rdata_o,
    output logic [mem_map_pkg::ADDR_W-1:0]    inst_addr_out_o,
    output logic                              inst_data_ok_o,
    // toward the read arbiter
    output logic                              ir_arvalid_o,
    input  wire                               ir_arready_i,
    output logic [mem_map_pkg::ADDR_W-1:0]    ir_araddr_o,
    output logic [axi_rd_pkg::AXI_LEN_W-1:0]  ir_arlen_o,
    input  wire  [axi_rd_pkg::AXI_DATA_W-1:0] ir_rdata_i,
    input  wire                               ir_rlast_i,
    input  wire                               ir_rvalid_i
);
    import axi_rd_pkg::*;
    import mem_map_pkg::*;

    localparam logic [1:0] S_IDLE = 2'd0;
    localparam logic [1:0] S_ADDR = 2'd1;
    localparam logic [1:0] S_BEAT = 2'd2;

    logic [1:0]            state_q;
    logic [BANK_W-1:0]     beat_cnt_q;       // index of the next beat in the line
    logic                  data_ok_q;
    phys_addr_u            req_addr_q;
    logic [AXI_DATA_W-1:0] word_q;
    logic                  take_req;
    logic                  beat_hit;

    // the arbiter matches rid against this value at AXI_ID_W bits
    if (INST_ID >= (1 << AXI_ID_W)) begin : g_id_range
        $error("INST_ID does not fit in the AXI ID field");
    end

    assign take_req = inst_req_i && (state_q == S_IDLE);
    assign beat_hit = (state_q == S_BEAT) && ir_rvalid_i;

    always_ff @(posedge aclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q    <= S_IDLE;
            beat_cnt_q <= '0;
            data_ok_q  <= 1'b0;
        end else begin
            data_ok_q <= 1'b0;                // single cycle pulse
            case (state_q)
                S_IDLE: begin
                    if (take_req) begin
                        state_q <= S_ADDR;
                    end
                end
                S_ADDR: begin
                    beat_cnt_q <= '0;
                    if (ir_arready_i) begin
                        state_q <= S_BEAT;
                    end
                end
                S_BEAT: begin
                    if (ir_rvalid_i) begin
                        beat_cnt_q <= beat_cnt_q + 1'b1;
                        if (ir_rlast_i) begin
                            state_q   <= S_IDLE;
                            data_ok_q <= 1'b1;    // word is valid once the burst ends
                        end
                    end
                end
                default: begin
                    state_q <= S_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (take_req) begin
            req_addr_q.raw <= inst_addr_i;
        end
        if (beat_hit && (beat_cnt_q == req_addr_q.line.bank)) begin
            word_q <= ir_rdata_i;             // keep only the requested word
        end
    end

    assign inst_addr_ready_o = (state_q == S_IDLE);
    assign inst_data_ok_o    = data_ok_q;
    assign inst_rdata_o      = word_q;
    assign inst_addr_out_o   = req_addr_q.raw;

    // whole line from its first word
    assign ir_arvalid_o = (state_q == S_ADDR);
    assign ir_araddr_o  = {req_addr_q.line.prefix, {(BANK_W + OFFSET_W){1'b0}}};
    assign ir_arlen_o   = AXI_LEN_W'(LINE_WORDS - 1);

endmodule

`default_nettype wire

/* verilog/mem_map_pkg.sv */
`default_nettype none

package mem_map_pkg;

    localparam int ADDR_W     = 32;
    localparam int LINE_WORDS = 8;                   // words per cache line

    localparam int OFFSET_W = 2;                     // byte inside a word
    localparam int BANK_W   = $clog2(LINE_WORDS);    // word inside a line
    localparam int PREFIX_W = ADDR_W - BANK_W - OFFSET_W;

    // one physical address seen either as a flat word or split by line geometry
    typedef union packed {
        logic [ADDR_W-1:0] raw;
        struct packed {
            logic [PREFIX_W-1:0] prefix;             // selects the line
            logic [BANK_W-1:0]   bank;               // selects the word in the line
            logic [OFFSET_W-1:0] offset;
        } line;
    } phys_addr_u;

endpackage

`default_nettype wire

/* verilog/mem_read_top.sv */
`default_nettype none

module mem_read_top #(
    parameter int unsigned INST_ID = 0,
    parameter int unsigned DATA_ID = 1
) (
    input  wire                               aclk,
    input  wire                               arst_n_i,
    // instruction fetch
    input  wire                               inst_req_i,
    input  wire  [mem_map_pkg::ADDR_W-1:0]    inst_addr_i,
    output logic                              inst_addr_ready_o,
    output logic [axi_rd_pkg::AXI_DATA_W-1:0] inst_rdata_o,
    output logic [mem_map_pkg::ADDR_W-1:0]    inst_addr_out_o,
    output logic                              inst_data_ok_o,
    // uncached load
    input  wire                               data_req_i,
    input  wire  [mem_map_pkg::ADDR_W-1:0]    data_addr_i,
    output logic                              data_addr_ok_o,
    output logic                              data_data_ok_o,
    output logic [axi_rd_pkg::AXI_DATA_W-1:0] data_rdata_o,
    // AXI read master
    output logic [axi_rd_pkg::AXI_ID_W-1:0]   arid_o,
    output logic [mem_map_pkg::ADDR_W-1:0]    araddr_o,
    output logic [axi_rd_pkg::AXI_LEN_W-1:0]  arlen_o,
    output logic                              arvalid_o,
    input  wire                               arready_i,
    input  wire  [axi_rd_pkg::AXI_ID_W-1:0]   rid_i,
    input  wire  [axi_rd_pkg::AXI_DATA_W-1:0] rdata_i,
    input  wire                               rlast_i,
    input  wire                               rvalid_i,
    output logic                              rready_o
);
    import axi_rd_pkg::*;
    import mem_map_pkg::*;

    logic                  ir_arvalid;
    logic                  ir_arready;
    logic [ADDR_W-1:0]     ir_araddr;
    logic [AXI_LEN_W-1:0]  ir_arlen;
    logic [AXI_DATA_W-1:0] ir_rdata;
    logic                  ir_rlast;
    logic                  ir_rvalid;

    logic                  mr_arvalid;
    logic                  mr_arready;
    logic [ADDR_W-1:0]     mr_araddr;
    logic [AXI_LEN_W-1:0]  mr_arlen;
    logic [AXI_DATA_W-1:0] mr_rdata;
    logic                  mr_rvalid;

    inst_line_fetch #(
        .INST_ID(INST_ID)
    ) u_inst_fetch (
        .aclk              (aclk),
        .arst_n_i          (arst_n_i),
        .inst_req_i        (inst_req_i),
        .inst_addr_i       (inst_addr_i),
        .inst_addr_ready_o (inst_addr_ready_o),
        .inst_rdata_o      (inst_rdata_o),
        .inst_addr_out_o   (inst_addr_out_o),
        .inst_data_ok_o    (inst_data_ok_o),
        .ir_arvalid_o      (ir_arvalid),
        .ir_arready_i      (ir_arready),
        .ir_araddr_o       (ir_araddr),
        .ir_arlen_o        (ir_arlen),
        .ir_rdata_i        (ir_rdata),
        .ir_rlast_i        (ir_rlast),
        .ir_rvalid_i       (ir_rvalid)
    );

    data_read_port #(
        .DATA_ID(DATA_ID)
    ) u_data_port (
        .aclk           (aclk),
        .arst_n_i       (arst_n_i),
        .data_req_i     (data_req_i),
        .data_addr_i    (data_addr_i),
        .data_addr_ok_o (data_addr_ok_o),
        .data_data_ok_o (data_data_ok_o),
        .data_rdata_o   (data_rdata_o),
        .mr_arvalid_o   (mr_arvalid),
        .mr_arready_i   (mr_arready),
        .mr_araddr_o    (mr_araddr),
        .mr_arlen_o     (mr_arlen),
        .mr_rdata_i     (mr_rdata),
        .mr_rvalid_i    (mr_rvalid)
    );

    axi_read_arbiter #(
        .INST_ID(INST_ID),
        .DATA_ID(DATA_ID)
    ) u_rd_arb (
        .aclk         (aclk),
        .arst_n_i     (arst_n_i),
        .ir_arvalid_i (ir_arvalid),
        .ir_arready_o (ir_arready),
        .ir_araddr_i  (ir_araddr),
        .ir_arlen_i   (ir_arlen),
        .ir_rdata_o   (ir_rdata),
        .ir_rlast_o   (ir_rlast),
        .ir_rvalid_o  (ir_rvalid),
        .mr_arvalid_i (mr_arvalid),
        .mr_arready_o (mr_arready),
        .mr_araddr_i  (mr_araddr),
        .mr_arlen_i   (mr_arlen),
        .mr_rdata_o   (mr_rdata),
        .mr_rvalid_o  (mr_rvalid),
        .arid_o       (arid_o),
        .araddr_o     (araddr_o),
        .arlen_o      (arlen_o),
        .arvalid_o    (arvalid_o),
        .arready_i    (arready_i),
        .rid_i        (rid_i),
        .rdata_i      (rdata_i),
        .rlast_i      (rlast_i),
        .rvalid_i     (rvalid_i),
        .rready_o     (rready_o)
    );

endmodule

`default_nettype wire
